// ==== alu.sv ====
`default_nettype none

`include "rv_settings.svh"

module alu (
	input wire rv_pkg::alu_ctl_t alu_ctl,
	input wire logic funct7_b5,
	input wire rv_pkg::word_t a,
	input wire rv_pkg::word_t b,
	output rv_pkg::word_t y
);
	import rv_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (alu_ctl)
			`ALU_ADD: y = a + b;
			`ALU_SUB: y = a - b;
			`ALU_SLL: y = a << shamt;
			`ALU_SLT: y = word_t'($signed(a) < $signed(b));
			`ALU_SLTU: y = word_t'(a < b);
			`ALU_XOR: y = a ^ b;
			`ALU_SRL_SRA: begin
				// bit 30 picks sra
				if (funct7_b5) begin
					y = $signed(a) >>> shamt;
				end else begin
					y = a >> shamt;
				end
			end
			`ALU_OR: y = a | b;
			`ALU_AND: y = a & b;
			default: y = a + b;
		endcase
	end

endmodule

`default_nettype wire

// ==== branch_unit.sv ====
`default_nettype none

`include "rv_settings.svh"

module branch_unit (
	input wire rv_pkg::decode_ctl_t ctl,
	input wire rv_pkg::word_t rs1,
	input wire rv_pkg::word_t rs2,
	input wire rv_pkg::word_t pc,
	output rv_pkg::word_t next_pc
);
	import rv_pkg::*;

	logic taken;
	word_t pc_plus4;
	word_t pc_target;
	word_t jalr_sum;

	always_comb begin
		case (ctl.funct3)
			`FNC_BEQ: taken = (rs1 == rs2);
			`FNC_BNE: taken = (rs1 != rs2);
			`FNC_BLT: taken = ($signed(rs1) < $signed(rs2));
			`FNC_BGE: taken = ($signed(rs1) >= $signed(rs2));
			`FNC_BLTU: taken = (rs1 < rs2);
			`FNC_BGEU: taken = (rs1 >= rs2);
			default: taken = 1'b0;
		endcase
	end

	assign pc_plus4 = pc + word_t'(4);
	assign pc_target = pc + ctl.imm;
	assign jalr_sum = rs1 + ctl.imm;

	always_comb begin
		if (ctl.pc_sel_bit0 && ctl.jop) begin
			// jalr drops bit 0
			next_pc = {jalr_sum[`XLEN-1:1], 1'b0};
		end else if (ctl.pc_sel_bit0 || (ctl.branch && taken)) begin
			next_pc = pc_target;
		end else begin
			next_pc = pc_plus4;
		end
	end

endmodule

`default_nettype wire

// ==== exec_core.sv ====
`default_nettype none

module exec_core (
	input wire logic clk,
	input wire logic rst,
	input wire logic instr_valid,
	input wire rv_pkg::word_t instr,
	output logic retire_valid,
	output rv_pkg::retire_t retire,
	output logic mem_valid,
	output rv_pkg::mem_req_t mem_req
);
	import rv_pkg::*;

	decode_ctl_t id_ctl;
	word_t id_rdata1;
	word_t id_rdata2;
	word_t id_rs1;
	word_t id_rs2;

	logic ex_valid;
	decode_ctl_t ex_ctl;
	word_t ex_rs1;
	word_t ex_rs2;
	word_t pc;
	word_t ex_op_a;
	word_t ex_op_b;
	word_t ex_alu_y;
	word_t ex_next_pc;
	word_t ex_link;
	word_t ex_wb_data;
	logic ex_wr;

	mini_decode u_decode (
		.instr (instr),
		.ctl   (id_ctl)
	);

	reg_file u_reg_file (
		.clk      (clk),
		.rst      (rst),
		.rd_addr1 (id_ctl.adr1),
		.rd_addr2 (id_ctl.adr2),
		.rd_data1 (id_rdata1),
		.rd_data2 (id_rdata2),
		.wr_en    (ex_wr),
		.wr_addr  (ex_ctl.rd),
		.wr_data  (ex_wb_data)
	);

	// ex-to-decode bypass
	assign id_rs1 = (ex_wr && (ex_ctl.rd == id_ctl.adr1)) ? ex_wb_data : id_rdata1;
	assign id_rs2 = (ex_wr && (ex_ctl.rd == id_ctl.adr2)) ? ex_wb_data : id_rdata2;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ex_ctl <= id_ctl;
			ex_rs1 <= id_rs1;
			ex_rs2 <= id_rs2;
		end
	end

	always_comb begin
		case (ex_ctl.op_a_sel)
			2'b01: ex_op_a = pc;
			2'b10: ex_op_a = '0;
			default: ex_op_a = ex_rs1;
		endcase
	end

	assign ex_op_b = ex_ctl.op_b_sel ? ex_rs2 : ex_ctl.imm;

	alu u_alu (
		.alu_ctl   (ex_ctl.alu_ctl),
		.funct7_b5 (ex_ctl.funct7[5]),
		.a         (ex_op_a),
		.b         (ex_op_b),
		.y         (ex_alu_y)
	);

	branch_unit u_branch (
		.ctl     (ex_ctl),
		.rs1     (ex_rs1),
		.rs2     (ex_rs2),
		.pc      (pc),
		.next_pc (ex_next_pc)
	);

	assign ex_link = pc + word_t'(4);
	assign ex_wb_data = (ex_ctl.wb_sel == 2'b10) ? ex_link : ex_alu_y;

	// no load data, so loads never write
	assign ex_wr = ex_valid && ex_ctl.reg_write && (ex_ctl.wb_sel != 2'b01)
		&& (ex_ctl.rd != '0);

	// pc of the instruction now in execute
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (ex_valid) begin
			pc <= ex_next_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			mem_valid <= 1'b0;
		end else begin
			retire_valid <= ex_valid;
			mem_valid <= ex_valid && ex_ctl.mem_access;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			retire.pc <= pc;
			retire.next_pc <= ex_next_pc;
			retire.rd <= ex_wr ? ex_ctl.rd : '0;
			retire.wb_data <= ex_wb_data;
			retire.reg_write <= ex_wr;
			mem_req.addr <= ex_alu_y;
			mem_req.store_data <= ex_rs2;
			mem_req.write <= ex_ctl.mem_write;
		end
	end

	a_mem_in_retire: assert property (@(posedge clk) disable iff (rst)
		mem_valid |-> retire_valid);

endmodule

`default_nettype wire

// ==== mini_decode.sv ====
`default_nettype none

`include "rv_settings.svh"

module mini_decode (
	input wire rv_pkg::word_t instr,
	output rv_pkg::decode_ctl_t ctl
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	reg_addr_t rd_addr;

	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;
	word_t imm_shamt;

	logic alu_op;
	logic is_shift_imm;

	assign opcode = instr[6:0];
	assign rd_addr = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1_addr = instr[19:15];
	assign rs2_addr = instr[24:20];
	assign funct7 = instr[31:25];

	// sign-extended immediates
	assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
	assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_shamt = {{(`XLEN-5){1'b0}}, instr[24:20]};

	assign is_shift_imm = (funct3 == `FNC_SLL) || (funct3 == `FNC_SRL_SRA);

	always_comb begin
		ctl = '0;
		alu_op = 1'b0;

		case (opcode)
			`OPC_LUI: begin
				ctl.rd = rd_addr;
				ctl.imm = imm_u;
				ctl.reg_write = 1'b1;
				// zero + imm
				ctl.op_a_sel = 2'b10;
			end
			`OPC_AUIPC: begin
				ctl.rd = rd_addr;
				ctl.imm = imm_u;
				ctl.reg_write = 1'b1;
				ctl.op_a_sel = 2'b01;
			end
			`OPC_JAL: begin
				ctl.rd = rd_addr;
				ctl.imm = imm_j;
				ctl.reg_write = 1'b1;
				ctl.wb_sel = 2'b10;
				ctl.pc_sel_bit0 = 1'b1;
			end
			`OPC_JALR: begin
				ctl.rd = rd_addr;
				ctl.funct3 = funct3;
				ctl.adr1 = rs1_addr;
				ctl.imm = imm_i;
				ctl.reg_write = 1'b1;
				ctl.wb_sel = 2'b10;
				ctl.pc_sel_bit0 = 1'b1;
				ctl.jop = 1'b1;
			end
			`OPC_BRANCH: begin
				ctl.funct3 = funct3;
				ctl.adr1 = rs1_addr;
				ctl.adr2 = rs2_addr;
				ctl.imm = imm_b;
				ctl.branch = 1'b1;
			end
			`OPC_STORE: begin
				ctl.funct3 = funct3;
				ctl.adr1 = rs1_addr;
				ctl.adr2 = rs2_addr;
				ctl.imm = imm_s;
				ctl.mem_access = 1'b1;
				ctl.mem_write = 1'b1;
			end
			`OPC_LOAD: begin
				ctl.rd = rd_addr;
				ctl.funct3 = funct3;
				ctl.adr1 = rs1_addr;
				ctl.imm = imm_i;
				ctl.reg_write = 1'b1;
				ctl.wb_sel = 2'b01;
				ctl.mem_access = 1'b1;
			end
			`OPC_ARI_RTYPE: begin
				ctl.rd = rd_addr;
				ctl.funct3 = funct3;
				ctl.adr1 = rs1_addr;
				ctl.adr2 = rs2_addr;
				ctl.funct7 = funct7;
				ctl.reg_write = 1'b1;
				ctl.op_b_sel = 1'b1;
				alu_op = 1'b1;
			end
			`OPC_ARI_ITYPE: begin
				ctl.rd = rd_addr;
				ctl.funct3 = funct3;
				ctl.adr1 = rs1_addr;
				// shamt form keeps funct7 for srai
				if (is_shift_imm) begin
					ctl.funct7 = funct7;
					ctl.imm = imm_shamt;
				end else begin
					ctl.imm = imm_i;
				end
				ctl.reg_write = 1'b1;
				alu_op = 1'b1;
			end
			default: begin
				ctl = '0;
			end
		endcase

		if (alu_op) begin
			case (funct3)
				`FNC_ADD_SUB: begin
					if (instr[30] && (opcode == `OPC_ARI_RTYPE)) begin
						ctl.alu_ctl = `ALU_SUB;
					end else begin
						ctl.alu_ctl = `ALU_ADD;
					end
				end
				`FNC_SLL: ctl.alu_ctl = `ALU_SLL;
				`FNC_SLT: ctl.alu_ctl = `ALU_SLT;
				`FNC_SLTU: ctl.alu_ctl = `ALU_SLTU;
				`FNC_XOR: ctl.alu_ctl = `ALU_XOR;
				`FNC_SRL_SRA: ctl.alu_ctl = `ALU_SRL_SRA;
				`FNC_OR: ctl.alu_ctl = `ALU_OR;
				default: ctl.alu_ctl = `ALU_AND;
			endcase
		end else begin
			// address and upper-imm sums
			ctl.alu_ctl = `ALU_ADD;
		end
	end

	// branches must never touch the register file
	always_comb begin
		assert (!(ctl.branch && ctl.reg_write))
		else $error("decode: branch with reg_write set");
	end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

`include "rv_settings.svh"

module reg_file (
	input wire logic clk,
	input wire logic rst,
	input wire rv_pkg::reg_addr_t rd_addr1,
	input wire rv_pkg::reg_addr_t rd_addr2,
	output rv_pkg::word_t rd_data1,
	output rv_pkg::word_t rd_data2,
	input wire logic wr_en,
	input wire rv_pkg::reg_addr_t wr_addr,
	input wire rv_pkg::word_t wr_data
);
	import rv_pkg::*;

	word_t regs [`REG_COUNT];
	logic wr_live;

	// x0 is never written
	assign wr_live = wr_en && (wr_addr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// write-through on same-cycle read
	function automatic word_t read_port(input reg_addr_t addr);
		if (wr_live && (wr_addr == addr)) begin
			return wr_data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rd_data1 = read_port(rd_addr1);
		rd_data2 = read_port(rd_addr2);
	end

	a_x0_zero: assert property (@(posedge clk) disable iff (rst)
		(rd_addr1 == '0) |-> (rd_data1 == '0));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the testbench; exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module tb_exec_core -o sim_exec_core \
	&& ./obj_dir/sim_exec_core \
	|| exit 1

// ==== rv_pkg.sv ====
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [4:0] alu_ctl_t;

	// decoded instruction, decode to execute
	typedef struct packed {
		reg_addr_t rd;
		reg_addr_t adr1;
		reg_addr_t adr2;
		logic [2:0] funct3;
		logic [6:0] funct7;
		word_t imm;
		logic reg_write;
		logic op_b_sel;
		logic [1:0] op_a_sel;
		// 00 alu, 01 load, 10 pc+4
		logic [1:0] wb_sel;
		logic pc_sel_bit0;
		logic branch;
		logic jop;
		alu_ctl_t alu_ctl;
		logic mem_access;
		// stores only
		logic mem_write;
	} decode_ctl_t;

	typedef struct packed {
		word_t pc;
		word_t next_pc;
		reg_addr_t rd;
		word_t wb_data;
		logic reg_write;
	} retire_t;

	typedef struct packed {
		word_t addr;
		word_t store_data;
		logic write;
	} mem_req_t;

endpackage

`default_nettype wire

// ==== rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define XLEN      32
`define REG_COUNT 32

// base opcodes
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_ARI_ITYPE 7'b0010011
`define OPC_ARI_RTYPE 7'b0110011

// funct3 for arithmetic
`define FNC_ADD_SUB 3'b000
`define FNC_SLL     3'b001
`define FNC_SLT     3'b010
`define FNC_SLTU    3'b011
`define FNC_XOR     3'b100
`define FNC_SRL_SRA 3'b101
`define FNC_OR      3'b110
`define FNC_AND     3'b111

// funct3 for branches
`define FNC_BEQ  3'b000
`define FNC_BNE  3'b001
`define FNC_BLT  3'b100
`define FNC_BGE  3'b101
`define FNC_BLTU 3'b110
`define FNC_BGEU 3'b111

`define ALU_ADD     5'd0
`define ALU_SUB     5'd1
`define ALU_SLL     5'd2
`define ALU_SLT     5'd3
`define ALU_SLTU    5'd4
`define ALU_XOR     5'd5
`define ALU_SRL_SRA 5'd6
`define ALU_OR      5'd7
`define ALU_AND     5'd8

`endif

// ==== tb_exec_core.sv ====
`default_nettype none

`include "rv_settings.svh"

module tb_exec_core;
	timeunit 1ns;
	timeprecision 100ps;

	import rv_pkg::*;

	logic clk;
	logic rst;
	logic instr_valid;
	word_t instr;
	logic retire_valid;
	retire_t retire;
	logic mem_valid;
	mem_req_t mem_req;

	word_t lcg_state = 32'd36;
	word_t ref_regs [32];
	word_t ref_pc;
	int cycle = 0;
	int idle_cycles = 0;

	retire_t exp_retire_q [$];
	mem_req_t exp_mem_q [$];
	logic exp_has_mem_q [$];
	int exp_cycle_q [$];

	exec_core u_exec_core (
		.clk          (clk),
		.rst          (rst),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.retire_valid (retire_valid),
		.retire       (retire),
		.mem_valid    (mem_valid),
		.mem_req      (mem_req)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic fail_value(input string sig, input word_t got, input word_t exp);
		$display("Fail at %0t: %s got %h expected %h", $time, sig, got, exp);
		$display(">>> FAIL");
		$fatal(1, "value mismatch");
	endtask

	task automatic check_retire(input retire_t got, input retire_t exp);
		if (got.pc != exp.pc)
			fail_value("retire.pc", got.pc, exp.pc);
		if (got.next_pc != exp.next_pc)
			fail_value("retire.next_pc", got.next_pc, exp.next_pc);
		if (got.rd != exp.rd)
			fail_value("retire.rd", word_t'(got.rd), word_t'(exp.rd));
		if (got.reg_write != exp.reg_write)
			fail_value("retire.reg_write", word_t'(got.reg_write), word_t'(exp.reg_write));
		// value only meaningful when written
		if (exp.reg_write && (got.wb_data != exp.wb_data))
			fail_value("retire.wb_data", got.wb_data, exp.wb_data);
	endtask

	task automatic check_mem(input mem_req_t got, input mem_req_t exp);
		if (got.addr != exp.addr)
			fail_value("mem_req.addr", got.addr, exp.addr);
		if (got.write != exp.write)
			fail_value("mem_req.write", word_t'(got.write), word_t'(exp.write));
		if (exp.write && (got.store_data != exp.store_data))
			fail_value("mem_req.store_data", got.store_data, exp.store_data);
	endtask

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic word_t make_instr();
		int pick;
		logic [15:0] r1;
		logic [15:0] r2;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm12;
		logic [19:0] imm20;
		logic [12:0] boff;
		logic [20:0] joff;
		word_t ins;
		pick = int'(next_rand()) % 20;
		r1 = next_rand();
		r2 = next_rand();
		// x0..x7 only, so hazards are common
		rd = {2'b00, r1[2:0]};
		rs1 = {2'b00, r1[5:3]};
		rs2 = {2'b00, r1[8:6]};
		f3 = r1[11:9];
		imm12 = r2[11:0];
		imm20 = {r1[15:12], r2};
		boff = {r2[11:0], 1'b0};
		joff = {r1[15:12], r2, 1'b0};
		f7 = (r1[12] && (f3 == `FNC_ADD_SUB || f3 == `FNC_SRL_SRA)) ? 7'h20 : 7'h00;
		if (pick < 2) begin
			ins = {imm20, rd, `OPC_LUI};
		end else if (pick == 2) begin
			ins = {imm20, rd, `OPC_AUIPC};
		end else if (pick < 7) begin
			if (f3 == `FNC_SLL) begin
				ins = {7'h00, imm12[4:0], rs1, f3, rd, `OPC_ARI_ITYPE};
			end else if (f3 == `FNC_SRL_SRA) begin
				ins = {f7, imm12[4:0], rs1, f3, rd, `OPC_ARI_ITYPE};
			end else begin
				ins = {imm12, rs1, f3, rd, `OPC_ARI_ITYPE};
			end
		end else if (pick < 11 || pick == 19) begin
			ins = {f7, rs2, rs1, f3, rd, `OPC_ARI_RTYPE};
		end else if (pick < 13) begin
			// 010 and 011 are not branch codes
			if (f3 == 3'b010 || f3 == 3'b011) begin
				f3 = f3 ^ 3'b110;
			end
			ins = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], `OPC_BRANCH};
		end else if (pick == 13) begin
			ins = {joff[20], joff[10:1], joff[11], joff[19:12], rd, `OPC_JAL};
		end else if (pick == 14) begin
			ins = {imm12, rs1, 3'b000, rd, `OPC_JALR};
		end else if (pick < 17) begin
			if (f3 == 3'b011 || f3[2:1] == 2'b11) begin
				f3 = 3'b010;
			end
			ins = {imm12, rs1, f3, rd, `OPC_LOAD};
		end else begin
			if (f3[2] || f3[1:0] == 2'b11) begin
				f3 = 3'b010;
			end
			ins = {imm12[11:5], rs2, rs1, f3, imm12[4:0], `OPC_STORE};
		end
		return ins;
	endfunction

	// alt selects sub or sra
	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
		input word_t b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic void execute_reference(input word_t ins, output retire_t r,
		output logic has_mem, output mem_req_t m);
		logic [4:0] rd;
		logic [2:0] f3;
		word_t a;
		word_t b;
		word_t imm_i;
		word_t imm_s;
		word_t imm_b;
		word_t imm_j;
		word_t imm_u;
		word_t result;
		word_t npc;
		logic wr;
		logic taken;
		rd = ins[11:7];
		f3 = ins[14:12];
		a = ref_regs[ins[19:15]];
		b = ref_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		imm_u = {ins[31:12], 12'b0};
		result = '0;
		npc = ref_pc + 32'd4;
		wr = 1'b0;
		taken = 1'b0;
		has_mem = 1'b0;
		m = '0;
		case (ins[6:0])
			`OPC_LUI: begin
				result = imm_u;
				wr = 1'b1;
			end
			`OPC_AUIPC: begin
				result = ref_pc + imm_u;
				wr = 1'b1;
			end
			`OPC_JAL: begin
				result = ref_pc + 32'd4;
				npc = ref_pc + imm_j;
				wr = 1'b1;
			end
			`OPC_JALR: begin
				result = ref_pc + 32'd4;
				npc = (a + imm_i) & ~32'd1;
				wr = 1'b1;
			end
			`OPC_BRANCH: begin
				case (f3)
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = ($signed(a) < $signed(b));
					3'b101: taken = ($signed(a) >= $signed(b));
					3'b110: taken = (a < b);
					default: taken = (a >= b);
				endcase
				if (taken) begin
					npc = ref_pc + imm_b;
				end
			end
			`OPC_LOAD: begin
				has_mem = 1'b1;
				m.addr = a + imm_i;
			end
			`OPC_STORE: begin
				has_mem = 1'b1;
				m.addr = a + imm_s;
				m.store_data = b;
				m.write = 1'b1;
			end
			`OPC_ARI_ITYPE: begin
				result = alu_ref(f3, (f3 == 3'b101) && ins[30], a, imm_i);
				wr = 1'b1;
			end
			`OPC_ARI_RTYPE: begin
				result = alu_ref(f3, ins[30], a, b);
				wr = 1'b1;
			end
			default: begin
				wr = 1'b0;
			end
		endcase
		wr = wr && (rd != 5'd0);
		if (wr) begin
			ref_regs[rd] = result;
		end
		r.pc = ref_pc;
		r.next_pc = npc;
		r.rd = wr ? rd : 5'd0;
		r.wb_data = result;
		r.reg_write = wr;
		ref_pc = npc;
	endfunction

	task automatic compare_retire();
		retire_t exp_r;
		mem_req_t exp_m;
		logic exp_has;
		int exp_cyc;
		exp_r = exp_retire_q.pop_front();
		exp_m = exp_mem_q.pop_front();
		exp_has = exp_has_mem_q.pop_front();
		exp_cyc = exp_cycle_q.pop_front();
		if (cycle != exp_cyc)
			fail_value("retire latency cycle", word_t'(cycle), word_t'(exp_cyc));
		check_retire(retire, exp_r);
		if (mem_valid != exp_has)
			fail_value("mem_valid", word_t'(mem_valid), word_t'(exp_has));
		if (exp_has)
			check_mem(mem_req, exp_m);
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (!rst) begin
			if (mem_valid && !retire_valid) begin
				stop_run("mem_valid was raised without retire_valid");
			end else if (retire_valid) begin
				idle_cycles = 0;
				if (exp_retire_q.size() == 0) begin
					stop_run("retire_valid was raised with no instruction outstanding");
				end else begin
					compare_retire();
				end
			end else if (exp_retire_q.size() != 0) begin
				idle_cycles++;
				if (idle_cycles > 20) begin
					stop_run("timeout waiting for retire_valid");
				end
			end
		end
	end

	initial begin
		int gap;
		int waited;
		word_t ins;
		retire_t exp_r;
		logic has_mem;
		mem_req_t exp_m;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		ref_pc = '0;
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = '0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// quiet period after reset
		repeat (4) @(negedge clk);
		for (int n = 0; n < 2000; n++) begin
			ins = make_instr();
			instr = ins;
			instr_valid = 1'b1;
			execute_reference(ins, exp_r, has_mem, exp_m);
			exp_retire_q.push_back(exp_r);
			exp_mem_q.push_back(exp_m);
			exp_has_mem_q.push_back(has_mem);
			exp_cycle_q.push_back(cycle + 2);
			@(negedge clk);
			instr_valid = 1'b0;
			gap = int'(next_rand()) % 3;
			repeat (gap) @(negedge clk);
		end
		waited = 0;
		while (exp_retire_q.size() != 0 && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (exp_retire_q.size() == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			stop_run("timeout waiting for the last retires");
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
rv_pkg.sv
mini_decode.sv
reg_file.sv
alu.sv
branch_unit.sv
exec_core.sv
tb_exec_core.sv
